// ==== hdl/cache_pkg.sv ====
package cache_pkg;

    // Cache geometry
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int WORD_BITS = 2;
    localparam int BLOCK_BITS = 2;
    localparam int INDEX_BITS = 2;
    localparam int TAG_BITS = ADDR_WIDTH - INDEX_BITS - BLOCK_BITS - WORD_BITS;
    localparam int ASSOCIATIVITY = 2;
    localparam int WAY_BITS = 1;
    localparam int SEQ_ID_BITS = 4;
    localparam int LOCAL_ADDR_BITS = INDEX_BITS + BLOCK_BITS;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [DATA_WIDTH/8-1:0] strobe_t;
    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [BLOCK_BITS-1:0] block_t;
    typedef logic [WAY_BITS-1:0] way_t;
    typedef logic [LOCAL_ADDR_BITS-1:0] local_addr_t;
    typedef logic [SEQ_ID_BITS-1:0] seq_id_t;

    // Child address split into its fields
    typedef struct packed {
        tag_t tag;
        index_t index;
        block_t block;
        logic [WORD_BITS-1:0] word;
    } addr_fields_t;

    // Age 0 is the most recently used way
    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
        way_t age;
    } line_meta_t;

    typedef line_meta_t [ASSOCIATIVITY-1:0] set_meta_t;

    typedef enum logic [1:0] {
        NORMAL,
        EVICT,
        FILL,
        PENDING
    } ctrl_state_t;

    typedef struct packed {
        logic read_enable;
        strobe_t write_enable;
        local_addr_t addr;
        data_t data;
        seq_id_t id;
    } local_req_t;

    typedef struct packed {
        seq_id_t id;
        logic send_parent;
        addr_t addr;
    } meta_req_t;

    typedef struct packed {
        seq_id_t id;
        addr_t addr;
    } bypass_req_t;

endpackage

// ==== hdl/tag_store_if.sv ====
`timescale 1ns/1ps

interface tag_store_if;
    import cache_pkg::*;

    index_t index;
    logic write_enable;
    set_meta_t write_data;
    set_meta_t read_data;
    logic ready;

    modport controller (
        output index,
        output write_enable,
        output write_data,
        input  read_data,
        input  ready
    );

    modport store (
        input  index,
        input  write_enable,
        input  write_data,
        output read_data,
        output ready
    );

endinterface

// ==== hdl/tag_store.sv ====
`timescale 1ns/1ps

module tag_store (
    input  logic clk,
    input  logic reset,
    tag_store_if.store meta
);
    import cache_pkg::*;

    localparam int SETS = 2 ** INDEX_BITS;

    set_meta_t sets [SETS];
    index_t clear_index;
    logic clear_done;

    // Sweep every set once after reset, one set per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            clear_index <= '0;
            clear_done <= 1'b0;
        end else if (!clear_done) begin
            clear_index <= clear_index + 1'b1;
            if (clear_index == index_t'(SETS - 1)) begin
                clear_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!clear_done) begin
            sets[clear_index] <= '0;
        end else if (meta.write_enable) begin
            sets[meta.index] <= meta.write_data;
        end
    end

    assign meta.read_data = sets[meta.index];
    assign meta.ready = clear_done;

endmodule

// ==== hdl/way_select.sv ====
`timescale 1ns/1ps

module way_select (
    input  cache_pkg::set_meta_t set_in,
    input  cache_pkg::tag_t tag,
    output logic hit,
    output cache_pkg::way_t hit_way,
    output logic has_empty,
    output cache_pkg::way_t empty_way,
    output cache_pkg::way_t victim_way,
    output logic victim_dirty,
    output cache_pkg::tag_t victim_tag,
    input  cache_pkg::way_t touch_way,
    output cache_pkg::set_meta_t set_touched
);
    import cache_pkg::*;

    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        has_empty = 1'b0;
        empty_way = '0;
        victim_way = '0;

        for (int i = 0; i < ASSOCIATIVITY; i++) begin
            if (set_in[i].valid && set_in[i].tag == tag) begin
                hit = 1'b1;
                hit_way = way_t'(i);
            end
            if (set_in[i].age > set_in[victim_way].age) begin
                victim_way = way_t'(i);
            end
        end

        // Lowest numbered invalid way wins
        for (int i = ASSOCIATIVITY - 1; i >= 0; i--) begin
            if (!set_in[i].valid) begin
                has_empty = 1'b1;
                empty_way = way_t'(i);
            end
        end
    end

    assign victim_dirty = set_in[victim_way].dirty;
    assign victim_tag = set_in[victim_way].tag;

    // Ways no older than the touched one age by one, so the all-zero
    // ages left by clearing turn into a proper order
    always_comb begin
        set_touched = set_in;
        for (int i = 0; i < ASSOCIATIVITY; i++) begin
            if (way_t'(i) != touch_way && set_in[i].age <= set_in[touch_way].age) begin
                set_touched[i].age = set_in[i].age + 1'b1;
            end
        end
        set_touched[touch_way].age = '0;
    end

endmodule

// ==== hdl/miss_controller.sv ====
`timescale 1ns/1ps

module miss_controller (
    input  logic clk,
    input  logic reset,
    tag_store_if.controller meta,
    input  logic child_valid,
    output logic child_ready,
    input  logic child_read_enable,
    input  cache_pkg::strobe_t child_write_enable,
    input  cache_pkg::addr_t child_addr,
    input  cache_pkg::data_t child_data,
    input  cache_pkg::seq_id_t child_id,
    input  logic parent_valid,
    output logic parent_ready,
    input  cache_pkg::data_t parent_data,
    output logic local_valid,
    input  logic local_ready,
    output cache_pkg::local_req_t local_payload,
    output logic meta_valid,
    input  logic meta_ready,
    output cache_pkg::meta_req_t meta_payload,
    output logic bypass_valid,
    input  logic bypass_ready,
    output cache_pkg::bypass_req_t bypass_payload
);
    import cache_pkg::*;

    ctrl_state_t state, next_state;
    block_t front, next_front;
    block_t rear, next_rear;
    tag_t saved_tag, next_saved_tag;
    seq_id_t seq_id, next_seq_id;

    addr_fields_t fields;
    logic hit, has_empty, victim_dirty;
    way_t hit_way, empty_way, victim_way, fill_way;
    tag_t victim_tag;
    set_meta_t set_touched, write_set;

    logic consume_child, consume_parent;
    logic produce_local, produce_meta, produce_bypass;
    logic tag_write, fire;

    assign fields = child_addr;
    assign meta.index = fields.index;
    assign meta.write_data = write_set;
    assign fill_way = has_empty ? empty_way : victim_way;

    way_select way_select_i (
        .set_in(meta.read_data),
        .tag(fields.tag),
        .hit,
        .hit_way,
        .has_empty,
        .empty_way,
        .victim_way,
        .victim_dirty,
        .victim_tag,
        .touch_way(hit_way),
        .set_touched
    );

    always_comb begin
        next_state = state;
        next_front = front;
        next_rear = rear;
        next_saved_tag = saved_tag;
        next_seq_id = seq_id;

        consume_child = 1'b0;
        consume_parent = 1'b0;
        produce_local = 1'b0;
        produce_meta = 1'b0;
        produce_bypass = 1'b0;
        tag_write = 1'b0;
        write_set = meta.read_data;

        // Default local request is the child request itself
        local_payload = '{
            read_enable: child_read_enable,
            write_enable: child_write_enable,
            addr: {fields.index, fields.block},
            data: child_data,
            id: child_id
        };
        meta_payload = '{id: seq_id, send_parent: 1'b0, addr: child_addr};
        bypass_payload = '{
            id: seq_id,
            addr: {fields.tag, fields.index, front, {WORD_BITS{1'b0}}}
        };

        case (state)
            NORMAL: begin
                if (child_valid && hit) begin
                    consume_child = 1'b1;
                    produce_local = 1'b1;
                    produce_meta = child_read_enable;
                    tag_write = 1'b1;
                    write_set = set_touched;
                    write_set[hit_way].dirty = set_touched[hit_way].dirty | (|child_write_enable);
                    next_seq_id = seq_id + 1'b1;
                end else if (child_valid) begin
                    // Claim the victim way now, the request is retried after refill
                    tag_write = 1'b1;
                    write_set[fill_way].valid = 1'b1;
                    write_set[fill_way].dirty = 1'b0;
                    write_set[fill_way].tag = fields.tag;
                    next_saved_tag = victim_tag;
                    next_front = '0;
                    next_rear = '0;
                    next_state = (!has_empty && victim_dirty) ? EVICT : FILL;
                end
            end
            EVICT: begin
                produce_local = 1'b1;
                produce_meta = 1'b1;
                local_payload.read_enable = 1'b1;
                local_payload.write_enable = '0;
                local_payload.addr = {fields.index, front};
                meta_payload.send_parent = 1'b1;
                meta_payload.addr = {saved_tag, fields.index, front, {WORD_BITS{1'b0}}};
                next_seq_id = seq_id + 1'b1;
                next_front = front + 1'b1;
                if (&front) begin
                    next_state = FILL;
                end
            end
            FILL: begin
                produce_bypass = 1'b1;
                next_seq_id = seq_id + 1'b1;
                next_front = front + 1'b1;
                if (&front) begin
                    next_state = PENDING;
                end
                // Parent words are written as they come back
                consume_parent = parent_valid;
                produce_local = parent_valid;
                local_payload.read_enable = 1'b0;
                local_payload.write_enable = '1;
                local_payload.addr = {fields.index, rear};
                local_payload.data = parent_data;
                if (parent_valid) begin
                    next_rear = rear + 1'b1;
                end
            end
            PENDING: begin
                consume_parent = 1'b1;
                produce_local = 1'b1;
                local_payload.read_enable = 1'b0;
                local_payload.write_enable = '1;
                local_payload.addr = {fields.index, rear};
                local_payload.data = parent_data;
                next_rear = rear + 1'b1;
                if (&rear) begin
                    next_state = NORMAL;
                end
            end
            default: begin
                next_state = NORMAL;
            end
        endcase
    end

    // A step fires only when all chosen inputs and outputs can move
    assign fire = meta.ready
        && (!consume_child || child_valid)
        && (!consume_parent || parent_valid)
        && (!produce_local || local_ready)
        && (!produce_meta || meta_ready)
        && (!produce_bypass || bypass_ready);

    assign child_ready = fire && consume_child;
    assign parent_ready = fire && consume_parent;
    assign local_valid = fire && produce_local;
    assign meta_valid = fire && produce_meta;
    assign bypass_valid = fire && produce_bypass;
    assign meta.write_enable = fire && tag_write;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= NORMAL;
            front <= '0;
            rear <= '0;
            seq_id <= '0;
        end else if (fire) begin
            state <= next_state;
            front <= next_front;
            rear <= next_rear;
            seq_id <= next_seq_id;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            saved_tag <= next_saved_tag;
        end
    end

endmodule

// ==== hdl/stream_register.sv ====
`timescale 1ns/1ps

module stream_register #(
    parameter int WIDTH = 32
) (
    input  logic clk,
    input  logic reset,
    input  logic in_valid,
    output logic in_ready,
    input  logic [WIDTH-1:0] in_data,
    output logic out_valid,
    input  logic out_ready,
    output logic [WIDTH-1:0] out_data
);

    logic full;
    logic [WIDTH-1:0] data;

    // Room when empty or when the held item leaves this cycle
    assign in_ready = !full || out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data <= in_data;
        end
    end

    assign out_valid = full;
    assign out_data = data;

endmodule

// ==== hdl/cache_decode.sv ====
`timescale 1ns/1ps

module cache_decode (
    input  logic clk,
    input  logic reset,

    input  logic child_valid,
    output logic child_ready,
    input  logic child_read_enable,
    input  cache_pkg::strobe_t child_write_enable,
    input  cache_pkg::addr_t child_addr,
    input  cache_pkg::data_t child_data,
    input  cache_pkg::seq_id_t child_id,

    input  logic parent_valid,
    output logic parent_ready,
    input  cache_pkg::data_t parent_data,

    output logic local_valid,
    input  logic local_ready,
    output logic local_read_enable,
    output cache_pkg::strobe_t local_write_enable,
    output cache_pkg::local_addr_t local_addr,
    output cache_pkg::data_t local_data,
    output cache_pkg::seq_id_t local_id,

    output logic meta_valid,
    input  logic meta_ready,
    output cache_pkg::seq_id_t meta_id,
    output logic meta_send_parent,
    output cache_pkg::addr_t meta_addr,

    output logic bypass_valid,
    input  logic bypass_ready,
    output cache_pkg::seq_id_t bypass_id,
    output cache_pkg::addr_t bypass_addr
);
    import cache_pkg::*;

    logic local_next_valid, local_next_ready;
    logic meta_next_valid, meta_next_ready;
    logic bypass_next_valid, bypass_next_ready;
    local_req_t local_next, local_out;
    meta_req_t meta_next, meta_out;
    bypass_req_t bypass_next, bypass_out;

    tag_store_if tag_if ();

    tag_store tag_store_i (
        .clk,
        .reset,
        .meta(tag_if.store)
    );

    miss_controller miss_controller_i (
        .clk,
        .reset,
        .meta(tag_if.controller),
        .child_valid,
        .child_ready,
        .child_read_enable,
        .child_write_enable,
        .child_addr,
        .child_data,
        .child_id,
        .parent_valid,
        .parent_ready,
        .parent_data,
        .local_valid(local_next_valid),
        .local_ready(local_next_ready),
        .local_payload(local_next),
        .meta_valid(meta_next_valid),
        .meta_ready(meta_next_ready),
        .meta_payload(meta_next),
        .bypass_valid(bypass_next_valid),
        .bypass_ready(bypass_next_ready),
        .bypass_payload(bypass_next)
    );

    stream_register #(
        .WIDTH($bits(local_req_t))
    ) local_stage_i (
        .clk,
        .reset,
        .in_valid(local_next_valid),
        .in_ready(local_next_ready),
        .in_data(local_next),
        .out_valid(local_valid),
        .out_ready(local_ready),
        .out_data(local_out)
    );

    stream_register #(
        .WIDTH($bits(meta_req_t))
    ) meta_stage_i (
        .clk,
        .reset,
        .in_valid(meta_next_valid),
        .in_ready(meta_next_ready),
        .in_data(meta_next),
        .out_valid(meta_valid),
        .out_ready(meta_ready),
        .out_data(meta_out)
    );

    stream_register #(
        .WIDTH($bits(bypass_req_t))
    ) bypass_stage_i (
        .clk,
        .reset,
        .in_valid(bypass_next_valid),
        .in_ready(bypass_next_ready),
        .in_data(bypass_next),
        .out_valid(bypass_valid),
        .out_ready(bypass_ready),
        .out_data(bypass_out)
    );

    assign local_read_enable = local_out.read_enable;
    assign local_write_enable = local_out.write_enable;
    assign local_addr = local_out.addr;
    assign local_data = local_out.data;
    assign local_id = local_out.id;

    assign meta_id = meta_out.id;
    assign meta_send_parent = meta_out.send_parent;
    assign meta_addr = meta_out.addr;

    assign bypass_id = bypass_out.id;
    assign bypass_addr = bypass_out.addr;

endmodule

// ==== testbench/cache_decode_assertions.sv ====
`timescale 1ns/1ps

module cache_decode_assertions (
    input logic clk,
    input logic reset,
    input logic store_ready,
    input cache_pkg::ctrl_state_t state,
    input logic child_valid,
    input logic child_ready,
    input cache_pkg::addr_t child_addr
);
    import cache_pkg::*;

    // A waiting child request keeps its address until it is taken
    assert property (@(posedge clk) disable iff (reset)
        (child_valid && !child_ready) |=> (child_valid && $stable(child_addr)))
        else $error("child request changed while waiting for ready");

    // No request is taken during the four-cycle clearing sweep after reset
    assert property (@(posedge clk) disable iff (reset)
        child_ready |-> (store_ready && !$past(reset, 4)))
        else $error("child request accepted before the tag store was cleared");

    assert property (@(posedge clk) disable iff (reset)
        (state == NORMAL && !child_valid) |=> (state == NORMAL))
        else $error("controller left NORMAL without a child request");

endmodule

bind miss_controller cache_decode_assertions assertions_i (
    .clk(clk),
    .reset(reset),
    .store_ready(meta.ready),
    .state(state),
    .child_valid(child_valid),
    .child_ready(child_ready),
    .child_addr(child_addr)
);

// ==== testbench/cache_decode_tb.sv ====
`timescale 1ns/1ps

module cache_decode_tb;
    import cache_pkg::*;

    localparam int NUM_ROWS = 12;
    localparam int TIMEOUT_CYCLES = 60 * NUM_ROWS + 100;
    localparam logic [1:0] OUT_HIT = 2'd0;
    localparam logic [1:0] OUT_FILL = 2'd1;
    localparam logic [1:0] OUT_EVICT = 2'd2;
    localparam data_t RESPONSE_MASK = 32'h5a5a0000;

    typedef struct packed {
        logic is_read;
        addr_t addr;
        data_t data;
        strobe_t strobes;
        logic [1:0] outcome;
        tag_t victim_tag;
    } row_t;

    logic clk = 1'b0;
    logic reset;
    logic child_valid, child_ready, child_read_enable;
    strobe_t child_write_enable;
    addr_t child_addr;
    data_t child_data;
    seq_id_t child_id;
    logic parent_valid, parent_ready;
    data_t parent_data;
    logic local_valid, local_ready, local_read_enable;
    strobe_t local_write_enable;
    local_addr_t local_addr;
    data_t local_data;
    seq_id_t local_id;
    logic meta_valid, meta_ready, meta_send_parent;
    seq_id_t meta_id;
    addr_t meta_addr;
    logic bypass_valid, bypass_ready;
    seq_id_t bypass_id;
    addr_t bypass_addr;

    row_t rows [NUM_ROWS];
    int row_count;
    local_req_t local_q [$];
    meta_req_t meta_q [$];
    bypass_req_t bypass_q [$];
    data_t responses [$];
    seq_id_t exp_seq;
    int seed = 32'h6b41;
    int error_count;
    int item_count;
    int timeout_count;
    logic child_taken;
    logic parent_taken;

    always #10 clk = ~clk;

    cache_decode dut_i (.*);

    function automatic addr_t word_addr(tag_t tag, index_t index, block_t block);
        return {tag, index, block, 2'b00};
    endfunction

    function automatic logic random_ready();
        return ($random(seed) % 4) != 0;
    endfunction

    function automatic string outcome_name(logic [1:0] outcome);
        case (outcome)
            OUT_HIT: return "hit";
            OUT_FILL: return "fill";
            default: return "evict and fill";
        endcase
    endfunction

    task automatic add_row(logic is_read, tag_t tag, index_t index, block_t block, data_t data,
                           strobe_t strobes, logic [1:0] outcome, tag_t victim_tag);
        rows[row_count] = '{is_read, word_addr(tag, index, block), data, strobes, outcome,
                            victim_tag};
        row_count++;
    endtask

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] want);
        $display("ERROR %0t: %s is %h, expected %h", $time, name, got, want);
        error_count++;
    endtask

    task automatic report_failure(string what);
        $display("ERROR %0t: %s", $time, what);
        error_count++;
    endtask

    // Items each stream must carry for one row, in order
    task automatic expect_row(int r);
        row_t row;
        tag_t tag;
        index_t index;
        block_t block;
        seq_id_t id;
        local_req_t li;
        meta_req_t mi;
        bypass_req_t bi;
        row = rows[r];
        tag = row.addr[31:6];
        index = row.addr[5:4];
        block = row.addr[3:2];
        id = seq_id_t'(r);
        if (row.outcome == OUT_EVICT) begin
            for (int b = 0; b < 4; b++) begin
                li = '{read_enable: 1'b1, write_enable: '0, addr: {index, block_t'(b)},
                       data: '0, id: id};
                local_q.push_back(li);
                mi = '{id: exp_seq, send_parent: 1'b1,
                       addr: word_addr(row.victim_tag, index, block_t'(b))};
                meta_q.push_back(mi);
                exp_seq = exp_seq + 1'b1;
            end
        end
        if (row.outcome != OUT_HIT) begin
            for (int b = 0; b < 4; b++) begin
                bi = '{id: exp_seq, addr: word_addr(tag, index, block_t'(b))};
                bypass_q.push_back(bi);
                exp_seq = exp_seq + 1'b1;
            end
            for (int b = 0; b < 4; b++) begin
                li = '{read_enable: 1'b0, write_enable: '1, addr: {index, block_t'(b)},
                       data: word_addr(tag, index, block_t'(b)) ^ RESPONSE_MASK, id: id};
                local_q.push_back(li);
            end
        end
        // The request itself, as a hit
        li = '{read_enable: row.is_read, write_enable: row.strobes, addr: {index, block},
               data: row.data, id: id};
        local_q.push_back(li);
        if (row.is_read) begin
            mi = '{id: exp_seq, send_parent: 1'b0, addr: row.addr};
            meta_q.push_back(mi);
        end
        exp_seq = exp_seq + 1'b1;
    endtask

    task automatic check_local();
        local_req_t exp;
        if (local_q.size() == 0) begin
            report_failure("local request arrived with none expected");
        end else begin
            exp = local_q.pop_front();
            item_count++;
            if (local_read_enable !== exp.read_enable)
                report_mismatch("local_read_enable", 32'(local_read_enable),
                                32'(exp.read_enable));
            if (local_write_enable !== exp.write_enable)
                report_mismatch("local_write_enable", 32'(local_write_enable),
                                32'(exp.write_enable));
            if (local_addr !== exp.addr)
                report_mismatch("local_addr", 32'(local_addr), 32'(exp.addr));
            if (local_id !== exp.id)
                report_mismatch("local_id", 32'(local_id), 32'(exp.id));
            if (exp.write_enable != '0 && local_data !== exp.data)
                report_mismatch("local_data", local_data, exp.data);
        end
    endtask

    task automatic check_meta();
        meta_req_t exp;
        if (meta_q.size() == 0) begin
            report_failure("meta record arrived with none expected");
        end else begin
            exp = meta_q.pop_front();
            item_count++;
            if (meta_id !== exp.id)
                report_mismatch("meta_id", 32'(meta_id), 32'(exp.id));
            if (meta_send_parent !== exp.send_parent)
                report_mismatch("meta_send_parent", 32'(meta_send_parent),
                                32'(exp.send_parent));
            if (meta_addr !== exp.addr)
                report_mismatch("meta_addr", meta_addr, exp.addr);
        end
    endtask

    task automatic check_bypass();
        bypass_req_t exp;
        if (bypass_q.size() == 0) begin
            report_failure("bypass request arrived with none expected");
        end else begin
            exp = bypass_q.pop_front();
            item_count++;
            if (bypass_id !== exp.id)
                report_mismatch("bypass_id", 32'(bypass_id), 32'(exp.id));
            if (bypass_addr !== exp.addr)
                report_mismatch("bypass_addr", bypass_addr, exp.addr);
        end
    endtask

    // Sample transfers at the rising edge, drive new inputs at the falling edge
    task automatic step_cycle();
        @(posedge clk);
        parent_taken = parent_valid && parent_ready;
        if (child_valid && child_ready) child_taken = 1'b1;
        if (local_valid && local_ready) check_local();
        if (meta_valid && meta_ready) check_meta();
        if (bypass_valid && bypass_ready) begin
            check_bypass();
            responses.push_back(bypass_addr ^ RESPONSE_MASK);
        end
        if (parent_taken) void'(responses.pop_front());
        @(negedge clk);
        local_ready = random_ready();
        meta_ready = random_ready();
        bypass_ready = random_ready();
        if (!parent_valid || parent_taken) begin
            parent_valid = responses.size() != 0 && random_ready();
        end
        parent_data = parent_valid ? responses[0] : '0;
    endtask

    initial begin
        timeout_count = 0;
        while (timeout_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            timeout_count++;
        end
        $display("Run stopped after %0d cycles with requests still outstanding", timeout_count);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        reset = 1'b1;
        child_valid = 1'b0;
        child_read_enable = 1'b0;
        child_write_enable = '0;
        child_addr = '0;
        child_data = '0;
        child_id = '0;
        parent_valid = 1'b0;
        parent_data = '0;
        local_ready = 1'b0;
        meta_ready = 1'b0;
        bypass_ready = 1'b0;
        row_count = 0;
        error_count = 0;
        item_count = 0;
        exp_seq = '0;
        parent_taken = 1'b0;

        // Set 1 sees tags 100, 200 and 300 so LRU and dirty eviction get exercised
        //      read  tag          idx   blk   data          strobes  outcome    victim
        add_row(1'b0, 26'h100,     2'd1, 2'd2, 32'h11110000, 4'b0011, OUT_FILL,  26'h0);
        add_row(1'b1, 26'h100,     2'd1, 2'd1, 32'h0,        4'b0000, OUT_HIT,   26'h0);
        add_row(1'b1, 26'h200,     2'd1, 2'd0, 32'h0,        4'b0000, OUT_FILL,  26'h0);
        add_row(1'b0, 26'h300,     2'd1, 2'd3, 32'hc3c30003, 4'b1111, OUT_EVICT, 26'h100);
        add_row(1'b1, 26'h200,     2'd1, 2'd2, 32'h0,        4'b0000, OUT_HIT,   26'h0);
        add_row(1'b1, 26'h100,     2'd1, 2'd0, 32'h0,        4'b0000, OUT_EVICT, 26'h300);
        add_row(1'b0, 26'h055,     2'd2, 2'd1, 32'h00550100, 4'b0100, OUT_FILL,  26'h0);
        add_row(1'b0, 26'h055,     2'd2, 2'd3, 32'h00550300, 4'b1000, OUT_HIT,   26'h0);
        add_row(1'b1, 26'h200,     2'd1, 2'd3, 32'h0,        4'b0000, OUT_HIT,   26'h0);
        add_row(1'b1, 26'h300,     2'd1, 2'd0, 32'h0,        4'b0000, OUT_FILL,  26'h0);
        add_row(1'b1, 26'h3ffffff, 2'd0, 2'd2, 32'h0,        4'b0000, OUT_FILL,  26'h0);
        add_row(1'b0, 26'h3ffffff, 2'd0, 2'd0, 32'hffff0000, 4'b1111, OUT_HIT,   26'h0);

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int r = 0; r < row_count; r++) begin
            expect_row(r);
            child_read_enable = rows[r].is_read;
            child_write_enable = rows[r].strobes;
            child_addr = rows[r].addr;
            child_data = rows[r].data;
            child_id = seq_id_t'(r);
            child_valid = 1'b1;
            child_taken = 1'b0;
            while (!child_taken) step_cycle();
            child_valid = 1'b0;
            while (local_q.size() != 0 || meta_q.size() != 0 || bypass_q.size() != 0) begin
                step_cycle();
            end
            $display("Row %0d %s %s done, %0d errors so far", r,
                     rows[r].is_read ? "read" : "write", outcome_name(rows[r].outcome),
                     error_count);
        end

        // A few idle cycles catch any stray output
        repeat (8) step_cycle();
        if (responses.size() != 0) report_failure("parent responses were never consumed");

        $display("%0d rows run, %0d items checked, %0d errors", row_count, item_count,
                 error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== cache_decode.f ====
hdl/cache_pkg.sv
hdl/tag_store_if.sv
hdl/tag_store.sv
hdl/way_select.sv
hdl/miss_controller.sv
hdl/stream_register.sv
hdl/cache_decode.sv
testbench/cache_decode_assertions.sv
testbench/cache_decode_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the cache decode testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f cache_decode.f \
    --top-module cache_decode_tb \
    --Mdir obj_dir

./obj_dir/Vcache_decode_tb | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "Testbench reported a failure"
    exit 1
fi

echo "Testbench run clean"
